// ==== rtl/rv32i_types.sv ====
package rv32i_types;

	// one data word on the cpu side
	typedef logic [31:0] rv32i_word;

	// byte address as issued by the core
	typedef logic [31:0] rv32i_addr;

	// one enable per byte lane of a word
	typedef logic [3:0] byte_mask;

endpackage : rv32i_types

// ==== rtl/mem_line_pkg.sv ====
package mem_line_pkg;

	// cache geometry, shared by both caches
	localparam int num_sets = 8;
	localparam int line_bytes = 32;
	localparam int offset_bits = $clog2(line_bytes);
	localparam int index_bits = $clog2(num_sets);

	// one full line as moved on the memory side
	typedef logic [8*line_bytes-1:0] mem_line;

	// upper address bits naming a line
	typedef logic [31-offset_bits:0] line_addr;

	typedef logic [index_bits-1:0] set_index;
	typedef logic [31-offset_bits-index_bits:0] cache_tag;

	// word within a line
	typedef logic [offset_bits-3:0] word_sel;

	// line request between caches, prefetch, write buffer and arbiter
	typedef struct packed {
		logic read;
		logic write;
		line_addr addr;
		mem_line wdata;
	} line_req_t;

endpackage : mem_line_pkg

// ==== rtl/icache.sv ====
`timescale 1ns/100ps

module icache (
	input logic clk,
	input logic rst,

	input logic read,
	input rv32i_types::rv32i_addr addr,
	output logic resp,
	output rv32i_types::rv32i_word rdata,

	output mem_line_pkg::line_req_t mem_req,
	input logic mem_resp,
	input mem_line_pkg::mem_line mem_rdata
);

	typedef enum logic {
		idle,
		fill
	} state_t;

	state_t state;

	mem_line_pkg::mem_line lines [mem_line_pkg::num_sets];
	mem_line_pkg::cache_tag tags [mem_line_pkg::num_sets];
	logic [mem_line_pkg::num_sets-1:0] valid;

	mem_line_pkg::line_addr la;
	mem_line_pkg::set_index idx;
	mem_line_pkg::cache_tag tag;
	mem_line_pkg::word_sel wsel;
	logic req_read;
	logic active;
	logic hit;

	// address split
	assign la = addr[31:mem_line_pkg::offset_bits];
	assign idx = la[mem_line_pkg::index_bits-1:0];
	assign tag = la[$bits(mem_line_pkg::line_addr)-1:mem_line_pkg::index_bits];
	assign wsel = addr[mem_line_pkg::offset_bits-1:2];

	// new request only when not already answering it
	assign active = read && !resp;
	assign hit = valid[idx] && (tags[idx] == tag);

	// read-only side, the fill address follows the held cpu address
	assign mem_req = '{read: req_read, write: 1'b0, addr: la, wdata: '0};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			resp <= 1'b0;
			req_read <= 1'b0;
			valid <= '0;
		end else begin
			resp <= 1'b0;
			case (state)
				idle: begin
					if (active && hit) begin
						resp <= 1'b1;
					end else if (active) begin
						req_read <= 1'b1;
						state <= fill;
					end
				end
				fill: begin
					// back to idle, the retry then hits
					if (mem_resp) begin
						req_read <= 1'b0;
						valid[idx] <= 1'b1;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == idle && active && hit)
			rdata <= lines[idx][32*wsel +: 32];
		if (state == fill && mem_resp) begin
			lines[idx] <= mem_rdata;
			tags[idx] <= tag;
		end
	end

endmodule : icache

// ==== rtl/dcache.sv ====
`timescale 1ns/100ps

module dcache (
	input logic clk,
	input logic rst,

	input logic read,
	input logic write,
	input rv32i_types::byte_mask wmask,
	input rv32i_types::rv32i_addr addr,
	input rv32i_types::rv32i_word wdata,
	output logic resp,
	output rv32i_types::rv32i_word rdata,

	output mem_line_pkg::line_req_t mem_req,
	input logic mem_resp,
	input mem_line_pkg::mem_line mem_rdata
);

	typedef enum logic [1:0] {
		idle,
		write_back,
		fill
	} state_t;

	state_t state;

	mem_line_pkg::mem_line lines [mem_line_pkg::num_sets];
	mem_line_pkg::cache_tag tags [mem_line_pkg::num_sets];
	logic [mem_line_pkg::num_sets-1:0] valid;
	logic [mem_line_pkg::num_sets-1:0] dirty;

	mem_line_pkg::line_addr la;
	mem_line_pkg::set_index idx;
	mem_line_pkg::cache_tag tag;
	mem_line_pkg::word_sel wsel;

	logic req_read;
	logic req_write;
	mem_line_pkg::line_addr req_addr;
	mem_line_pkg::mem_line req_wdata;

	logic active;
	logic hit;
	logic victim_dirty;

	assign la = addr[31:mem_line_pkg::offset_bits];
	assign idx = la[mem_line_pkg::index_bits-1:0];
	assign tag = la[$bits(mem_line_pkg::line_addr)-1:mem_line_pkg::index_bits];
	assign wsel = addr[mem_line_pkg::offset_bits-1:2];

	assign active = (read || write) && !resp;
	assign hit = valid[idx] && (tags[idx] == tag);
	assign victim_dirty = valid[idx] && dirty[idx];

	assign mem_req = '{read: req_read, write: req_write, addr: req_addr, wdata: req_wdata};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			resp <= 1'b0;
			req_read <= 1'b0;
			req_write <= 1'b0;
			valid <= '0;
			dirty <= '0;
		end else begin
			resp <= 1'b0;
			case (state)
				idle: begin
					if (active && hit) begin
						resp <= 1'b1;
						if (write)
							dirty[idx] <= 1'b1;
					end else if (active && victim_dirty) begin
						req_write <= 1'b1;
						state <= write_back;
					end else if (active) begin
						req_read <= 1'b1;
						state <= fill;
					end
				end
				write_back: begin
					// victim accepted, now fetch the wanted line
					if (mem_resp) begin
						req_write <= 1'b0;
						req_read <= 1'b1;
						state <= fill;
					end
				end
				fill: begin
					if (mem_resp) begin
						req_read <= 1'b0;
						valid[idx] <= 1'b1;
						dirty[idx] <= 1'b0;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			idle: begin
				if (active && hit) begin
					if (read)
						rdata <= lines[idx][32*wsel +: 32];
					// merge the enabled bytes into the line
					for (int i = 0; i < $bits(rv32i_types::byte_mask); i++) begin
						if (write && wmask[i])
							lines[idx][32*wsel + 8*i +: 8] <= wdata[8*i +: 8];
					end
				end else if (active) begin
					req_addr <= victim_dirty ? {tags[idx], idx} : la;
					req_wdata <= lines[idx];
				end
			end
			write_back: begin
				if (mem_resp)
					req_addr <= la;
			end
			fill: begin
				if (mem_resp) begin
					lines[idx] <= mem_rdata;
					tags[idx] <= tag;
				end
			end
			default: ;
		endcase
	end

endmodule : dcache

// ==== rtl/prefetch.sv ====
`timescale 1ns/100ps

module prefetch (
	input logic clk,
	input logic rst,

	input mem_line_pkg::line_req_t i_req,
	output logic i_resp,
	output mem_line_pkg::mem_line i_rdata,

	output mem_line_pkg::line_req_t pf_req,
	input logic pf_resp,
	input mem_line_pkg::mem_line pf_rdata
);

	typedef enum logic [1:0] {
		idle,
		fetch_demand,
		fetch_next
	} state_t;

	state_t state;

	// prefetched line
	logic buf_valid;
	mem_line_pkg::line_addr buf_addr;
	mem_line_pkg::mem_line buf_line;

	// next line waiting to be issued
	logic pend;
	mem_line_pkg::line_addr pend_addr;

	logic pf_read;
	mem_line_pkg::line_addr pf_addr;

	logic demand;
	logic buf_hit;

	assign demand = i_req.read && !i_resp;
	assign buf_hit = buf_valid && (buf_addr == i_req.addr);

	assign pf_req = '{read: pf_read, write: 1'b0, addr: pf_addr, wdata: '0};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			i_resp <= 1'b0;
			pf_read <= 1'b0;
			pend <= 1'b0;
			buf_valid <= 1'b0;
		end else begin
			i_resp <= 1'b0;
			case (state)
				idle: begin
					// demand beats a prefetch not yet issued
					if (demand && buf_hit) begin
						i_resp <= 1'b1;
					end else if (demand) begin
						pf_read <= 1'b1;
						state <= fetch_demand;
					end else if (pend) begin
						pf_read <= 1'b1;
						pend <= 1'b0;
						state <= fetch_next;
					end
				end
				fetch_demand: begin
					if (pf_resp) begin
						pf_read <= 1'b0;
						i_resp <= 1'b1;
						pend <= 1'b1;
						state <= idle;
					end
				end
				fetch_next: begin
					if (pf_resp) begin
						pf_read <= 1'b0;
						buf_valid <= 1'b1;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			idle: begin
				if (demand && buf_hit)
					i_rdata <= buf_line;
				else if (demand)
					pf_addr <= i_req.addr;
				else if (pend)
					pf_addr <= pend_addr;
			end
			fetch_demand: begin
				if (pf_resp) begin
					i_rdata <= pf_rdata;
					pend_addr <= pf_addr + mem_line_pkg::line_addr'(1);
				end
			end
			fetch_next: begin
				// buffer tag and data change together
				if (pf_resp) begin
					buf_line <= pf_rdata;
					buf_addr <= pf_addr;
				end
			end
			default: ;
		endcase
	end

endmodule : prefetch

// ==== rtl/write_buffer.sv ====
`timescale 1ns/100ps

module write_buffer (
	input logic clk,
	input logic rst,

	input mem_line_pkg::line_req_t d_req,
	output logic d_resp,
	output mem_line_pkg::mem_line d_rdata,

	output mem_line_pkg::line_req_t wb_req,
	input logic wb_resp,
	input mem_line_pkg::mem_line wb_rdata
);

	logic full;
	logic ack;
	mem_line_pkg::line_addr ent_addr;
	mem_line_pkg::mem_line ent_data;

	logic capture;
	logic pass_read;

	assign capture = d_req.write && !full && !ack;

	// reads wait while a victim is still pending
	assign pass_read = d_req.read && !full;

	assign d_resp = ack || (pass_read && wb_resp);
	assign d_rdata = wb_rdata;

	always_comb begin
		if (full) begin
			wb_req.read = 1'b0;
			wb_req.write = 1'b1;
			wb_req.addr = ent_addr;
			wb_req.wdata = ent_data;
		end else begin
			wb_req.read = d_req.read;
			wb_req.write = 1'b0;
			wb_req.addr = d_req.addr;
			wb_req.wdata = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			full <= 1'b0;
			ack <= 1'b0;
		end else begin
			ack <= capture;
			if (capture)
				full <= 1'b1;
			else if (full && wb_resp)
				full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			ent_addr <= d_req.addr;
			ent_data <= d_req.wdata;
		end
	end

endmodule : write_buffer

// ==== rtl/line_arbiter.sv ====
`timescale 1ns/100ps

module line_arbiter (
	input logic clk,
	input logic rst,

	// instruction side, through prefetch
	input mem_line_pkg::line_req_t pf_req,
	output logic pf_resp,
	output mem_line_pkg::mem_line pf_rdata,

	// data side, through the write buffer
	input mem_line_pkg::line_req_t wb_req,
	output logic wb_resp,
	output mem_line_pkg::mem_line wb_rdata,

	output logic pmem_read,
	output logic pmem_write,
	output rv32i_types::rv32i_addr pmem_address,
	output mem_line_pkg::mem_line pmem_wdata,
	input mem_line_pkg::mem_line pmem_rdata,
	input logic pmem_resp
);

	typedef enum logic [1:0] {
		idle,
		serve_i,
		serve_d
	} state_t;

	state_t state;
	mem_line_pkg::line_req_t granted;
	logic granted_any;

	assign granted = (state == serve_d) ? wb_req : pf_req;
	assign granted_any = (state != idle);

	// memory sees only the granted client
	assign pmem_read = granted_any && granted.read;
	assign pmem_write = granted_any && granted.write;
	assign pmem_address = {granted.addr, {mem_line_pkg::offset_bits{1'b0}}};
	assign pmem_wdata = granted.wdata;

	assign pf_resp = (state == serve_i) && pmem_resp;
	assign wb_resp = (state == serve_d) && pmem_resp;
	assign pf_rdata = pmem_rdata;
	assign wb_rdata = pmem_rdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					// data side first so a victim drains ahead of fetches
					if (wb_req.read || wb_req.write)
						state <= serve_d;
					else if (pf_req.read || pf_req.write)
						state <= serve_i;
				end
				serve_i: begin
					if (pmem_resp)
						state <= idle;
				end
				serve_d: begin
					if (pmem_resp)
						state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

endmodule : line_arbiter

// ==== rtl/mem_hierarchy.sv ====
`timescale 1ns/100ps

module mem_hierarchy (
	input logic clk,
	input logic rst,

	// port A, instruction fetch
	input logic read_a,
	input rv32i_types::rv32i_addr address_a,
	output logic resp_a,
	output rv32i_types::rv32i_word rdata_a,

	// port B, data
	input logic read_b,
	input logic write,
	input rv32i_types::byte_mask wmask,
	input rv32i_types::rv32i_addr address_b,
	input rv32i_types::rv32i_word wdata,
	output logic resp_b,
	output rv32i_types::rv32i_word rdata_b,

	// physical memory
	output logic pmem_read,
	output logic pmem_write,
	output rv32i_types::rv32i_addr pmem_address,
	output mem_line_pkg::mem_line pmem_wdata,
	input mem_line_pkg::mem_line pmem_rdata,
	input logic pmem_resp
);

	// icache to prefetch
	mem_line_pkg::line_req_t i_req;
	logic i_resp;
	mem_line_pkg::mem_line i_rdata;

	// prefetch to arbiter
	mem_line_pkg::line_req_t pf_req;
	logic pf_resp;
	mem_line_pkg::mem_line pf_rdata;

	// dcache to write buffer
	mem_line_pkg::line_req_t d_req;
	logic d_resp;
	mem_line_pkg::mem_line d_rdata;

	// write buffer to arbiter
	mem_line_pkg::line_req_t wb_req;
	logic wb_resp;
	mem_line_pkg::mem_line wb_rdata;

	icache icache (
		.clk,
		.rst,
		.read(read_a),
		.addr(address_a),
		.resp(resp_a),
		.rdata(rdata_a),
		.mem_req(i_req),
		.mem_resp(i_resp),
		.mem_rdata(i_rdata)
	);

	dcache dcache (
		.clk,
		.rst,
		.read(read_b),
		.write,
		.wmask,
		.addr(address_b),
		.wdata,
		.resp(resp_b),
		.rdata(rdata_b),
		.mem_req(d_req),
		.mem_resp(d_resp),
		.mem_rdata(d_rdata)
	);

	prefetch prefetch (
		.clk,
		.rst,
		.i_req,
		.i_resp,
		.i_rdata,
		.pf_req,
		.pf_resp,
		.pf_rdata
	);

	write_buffer write_buffer (
		.clk,
		.rst,
		.d_req,
		.d_resp,
		.d_rdata,
		.wb_req,
		.wb_resp,
		.wb_rdata
	);

	line_arbiter line_arbiter (
		.clk,
		.rst,
		.pf_req,
		.pf_resp,
		.pf_rdata,
		.wb_req,
		.wb_resp,
		.wb_rdata,
		.pmem_read,
		.pmem_write,
		.pmem_address,
		.pmem_wdata,
		.pmem_rdata,
		.pmem_resp
	);

endmodule : mem_hierarchy

// ==== bench/mem_hierarchy_assertions.sv ====
`timescale 1ns/100ps

module mem_hierarchy_assertions (
	input logic clk,
	input logic rst,
	input logic pmem_read,
	input logic pmem_write,
	input rv32i_types::rv32i_addr pmem_address,
	input logic pmem_resp,
	input logic pf_resp,
	input logic wb_resp
);

	// one direction at a time on the memory port
	read_write_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(pmem_read && pmem_write))
		else $error("pmem_read and pmem_write high together");

	read_held: assert property (@(posedge clk) disable iff (rst)
		pmem_read && !pmem_resp |=> pmem_read && $stable(pmem_address))
		else $error("pmem_read dropped or moved before pmem_resp");

	write_held: assert property (@(posedge clk) disable iff (rst)
		pmem_write && !pmem_resp |=> pmem_write && $stable(pmem_address))
		else $error("pmem_write dropped or moved before pmem_resp");

	// a client hears resp only while its granted request is on the memory port
	resp_needs_grant: assert property (@(posedge clk) disable iff (rst)
		(pf_resp || wb_resp) |-> (pmem_read || pmem_write))
		else $error("client resp without a granted request on the memory port");

endmodule : mem_hierarchy_assertions

bind line_arbiter mem_hierarchy_assertions arbiter_checks (
	.clk(clk),
	.rst(rst),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.pmem_address(pmem_address),
	.pmem_resp(pmem_resp),
	.pf_resp(pf_resp),
	.wb_resp(wb_resp)
);

// ==== bench/mem_hierarchy_tb.sv ====
`timescale 1ns/100ps

module mem_hierarchy_tb;

	localparam logic [31:0] rng_seed = 32'd76628;
	localparam int pmem_lines = 256;
	localparam int cycles_per_op = 64;

	// one line of the trace file
	typedef struct packed {
		logic [7:0] port;
		logic [7:0] op;
		rv32i_types::rv32i_addr addr;
		rv32i_types::byte_mask mask;
		rv32i_types::rv32i_word data;
		logic use_model;
		rv32i_types::rv32i_word expected;
	} trace_op_t;

	logic clk = 1'b0;
	logic rst = 1'b1;

	logic read_a = 1'b0;
	rv32i_types::rv32i_addr address_a = '0;
	logic resp_a;
	rv32i_types::rv32i_word rdata_a;

	logic read_b = 1'b0;
	logic write = 1'b0;
	rv32i_types::byte_mask wmask = '0;
	rv32i_types::rv32i_addr address_b = '0;
	rv32i_types::rv32i_word wdata = '0;
	logic resp_b;
	rv32i_types::rv32i_word rdata_b;

	logic pmem_read;
	logic pmem_write;
	rv32i_types::rv32i_addr pmem_address;
	mem_line_pkg::mem_line pmem_wdata;
	mem_line_pkg::mem_line pmem_rdata = '0;
	logic pmem_resp = 1'b0;

	trace_op_t ops [$];
	// words changed by earlier trace writes, keyed by word address
	rv32i_types::rv32i_word written [int unsigned];
	mem_line_pkg::mem_line pmem [pmem_lines];
	logic [pmem_lines-1:0] read_seen = '0;

	int mem_wait = 0;
	int writebacks = 0;
	int prefetch_checks = 0;
	int cycles = 0;
	int limit = 0;
	logic pend_a = 1'b0;
	logic pend_b = 1'b0;
	logic check_b = 1'b0;
	rv32i_types::rv32i_word exp_a;
	rv32i_types::rv32i_word exp_b;

	mem_hierarchy uut (
		.clk,
		.rst,
		.read_a,
		.address_a,
		.resp_a,
		.rdata_a,
		.read_b,
		.write,
		.wmask,
		.address_b,
		.wdata,
		.resp_b,
		.rdata_b,
		.pmem_read,
		.pmem_write,
		.pmem_address,
		.pmem_wdata,
		.pmem_rdata,
		.pmem_resp
	);

	initial begin
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ rng_seed;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic rv32i_types::rv32i_word model_word(input rv32i_types::rv32i_addr a);
		int unsigned key;
		key = {2'b00, a[31:2]};
		if (written.exists(key))
			return written[key];
		return xorshift(key);
	endfunction

	function automatic rv32i_types::rv32i_word merge_bytes(
		input rv32i_types::rv32i_word old_word,
		input rv32i_types::rv32i_word new_word,
		input rv32i_types::byte_mask mask
	);
		rv32i_types::rv32i_word r;
		r = old_word;
		for (int i = 0; i < 4; i++) begin
			if (mask[i])
				r[8*i +: 8] = new_word[8*i +: 8];
		end
		return r;
	endfunction

	function automatic mem_line_pkg::mem_line model_line(input rv32i_types::rv32i_addr a);
		mem_line_pkg::mem_line l;
		for (int w = 0; w < 8; w++)
			l[32*w +: 32] = model_word({a[31:5], 3'(w), 2'b00});
		return l;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input rv32i_types::rv32i_word got,
			input rv32i_types::rv32i_word exp);
		if (got !== exp)
			abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_line(input string name, input mem_line_pkg::mem_line got,
			input mem_line_pkg::mem_line exp);
		if (got !== exp)
			abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic read_trace;
		int fd;
		int n;
		string text;
		trace_op_t t;
		logic [7:0] port_c;
		logic [7:0] op_c;
		logic [63:0] exp_s;
		rv32i_types::rv32i_addr addr;
		rv32i_types::byte_mask mask;
		rv32i_types::rv32i_word data;
		rv32i_types::rv32i_word expected;
		fd = $fopen("bench/mem_trace.txt", "r");
		if (fd == 0)
			abort_run("cannot open the trace file bench/mem_trace.txt");
		while ($fgets(text, fd) != 0) begin
			if (text.len() < 2 || text[0] == "#")
				continue;
			n = $sscanf(text, "%s %s %h %h %h %s", port_c, op_c, addr, mask, data, exp_s);
			if (n != 6)
				abort_run($sformatf("malformed trace line: %s", text));
			expected = '0;
			// a dash means the value comes from the memory model
			if (exp_s[7:0] != "-")
				n = $sscanf(text, "%s %s %h %h %h %h", port_c, op_c, addr, mask, data,
					expected);
			if (addr[31:13] != '0)
				abort_run($sformatf("trace address %h lies outside the memory model", addr));
			t.port = port_c;
			t.op = op_c;
			t.addr = addr;
			t.mask = mask;
			t.data = data;
			t.use_model = (exp_s[7:0] == "-");
			t.expected = expected;
			ops.push_back(t);
		end
		$fclose(fd);
	endtask

	task automatic start_op(input trace_op_t t);
		rv32i_types::rv32i_word exp;
		exp = t.use_model ? model_word(t.addr) : t.expected;
		if (t.port == "A") begin
			// next line must already have gone out as a prefetch
			if (t.op == "F") begin
				if (!read_seen[t.addr[12:5]])
					abort_run($sformatf("line at %h was not prefetched before its demand", t.addr));
				prefetch_checks++;
			end
			read_a <= 1'b1;
			address_a <= t.addr;
			exp_a = exp;
			pend_a = 1'b1;
		end else begin
			address_b <= t.addr;
			if (t.op == "W" || t.op == "w") begin
				write <= 1'b1;
				wmask <= t.mask;
				wdata <= t.data;
				written[{2'b00, t.addr[31:2]}] = merge_bytes(model_word(t.addr), t.data, t.mask);
				check_b = 1'b0;
			end else begin
				read_b <= 1'b1;
				exp_b = exp;
				check_b = 1'b1;
			end
			pend_b = 1'b1;
		end
	endtask

	task automatic wait_done;
		logic got_a;
		logic got_b;
		while (pend_a || pend_b) begin
			@(negedge clk);
			got_a = pend_a && resp_a;
			got_b = pend_b && resp_b;
			if (got_a)
				check_word("rdata_a", rdata_a, exp_a);
			if (got_b && check_b)
				check_word("rdata_b", rdata_b, exp_b);
			@(posedge clk);
			if (got_a) begin
				read_a <= 1'b0;
				pend_a = 1'b0;
			end
			if (got_b) begin
				read_b <= 1'b0;
				write <= 1'b0;
				pend_b = 1'b0;
			end
		end
	endtask

	// physical memory, answers on the fourth cycle of a request
	always @(posedge clk) begin
		pmem_resp <= 1'b0;
		if (rst) begin
			mem_wait <= 0;
		end else if ((pmem_read || pmem_write) && !pmem_resp) begin
			if (pmem_address[31:13] != '0)
				abort_run($sformatf("memory access at %h outside the model", pmem_address));
			if (mem_wait == 3) begin
				mem_wait <= 0;
				pmem_resp <= 1'b1;
				if (pmem_write) begin
					check_line("pmem_wdata", pmem_wdata, model_line(pmem_address));
					pmem[pmem_address[12:5]] = pmem_wdata;
					writebacks++;
				end else begin
					pmem_rdata <= pmem[pmem_address[12:5]];
				end
			end else begin
				mem_wait <= mem_wait + 1;
			end
		end
	end

	// lines requested from memory so far
	always @(negedge clk) begin
		if (!rst && pmem_read)
			read_seen[pmem_address[12:5]] = 1'b1;
	end

	always @(posedge clk) begin
		cycles++;
		if (limit != 0 && cycles > limit)
			abort_run($sformatf("run did not finish within %0d cycles", limit));
	end

	initial begin
		for (int i = 0; i < pmem_lines; i++) begin
			for (int w = 0; w < 8; w++)
				pmem[i][32*w +: 32] = xorshift(32'(8*i + w));
		end
		read_trace();
		limit = ops.size() * cycles_per_op;

		repeat (9) @(posedge clk);
		@(negedge clk);
		check_flag("resp_a", resp_a, 1'b0);
		check_flag("resp_b", resp_b, 1'b0);
		check_flag("pmem_read", pmem_read, 1'b0);
		check_flag("pmem_write", pmem_write, 1'b0);
		@(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		// lower case ops stay open and run alongside the next one
		foreach (ops[i]) begin
			start_op(ops[i]);
			if (ops[i].op == "R" || ops[i].op == "W" || ops[i].op == "F") begin
				wait_done();
				@(posedge clk);
			end
		end
		wait_done();

		if (writebacks != 0 && prefetch_checks != 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			abort_run("trace ended without a dirty write-back and a prefetch check");
		end
	end

endmodule : mem_hierarchy_tb

// ==== bench/mem_trace.txt ====
# port(A/B) op(R read, W write, F fetch of a prefetched line) address mask data expected
# lower case op starts alongside the next line; expected '-' takes the memory model value
A R 00000000 0 00000000 -
A R 00000004 0 00000000 -
B R 00000400 0 00000000 -
B W 00000404 f 12345678 -
B W 00000408 5 a5a5a5a5 -
B R 00000404 0 00000000 12345678
B R 00000408 0 00000000 -
B R 00000500 0 00000000 -
B R 00000404 0 00000000 12345678
A R 0000001c 0 00000000 -
A F 00000020 0 00000000 -
A r 00000060 0 00000000 -
B W 0000050c 3 cafef00d -
B R 0000050c 0 00000000 -
A r 00000064 0 00000000 -
B R 00000608 0 00000000 -

// ==== list.f ====
rtl/rv32i_types.sv
rtl/mem_line_pkg.sv
rtl/icache.sv
rtl/dcache.sv
rtl/prefetch.sv
rtl/write_buffer.sv
rtl/line_arbiter.sv
rtl/mem_hierarchy.sv
bench/mem_hierarchy_assertions.sv
bench/mem_hierarchy_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= mem_hierarchy_tb
FILE_LIST ?= list.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILE_LIST)))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q '^PASS: all tests$$'

clean:
	rm -rf $(OBJ_DIR)
